// ==== src/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

    //////////////////////////////
    // widths and basic types
    //////////////////////////////

    localparam int SLV_NB = 3;
    localparam int ADDR_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 4;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;
    // beats minus one
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [1:0]        resp_t;
    // one bit per slave
    typedef logic [SLV_NB-1:0] slv_sel_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    //////////////////////////////
    // address map and limits
    //////////////////////////////

    // inclusive windows, indexed by slave
    localparam addr_t SLV_START [SLV_NB] = '{addr_t'(0),    addr_t'(4096), addr_t'(8192)};
    localparam addr_t SLV_END   [SLV_NB] = '{addr_t'(4095), addr_t'(8191), addr_t'(12287)};

    localparam int OSTD_MAX  = 4;
    localparam int ERR_DEPTH = 4;

    typedef logic [$clog2(OSTD_MAX+1)-1:0] ost_cnt_t;

    //////////////////////////////
    // channel payloads
    //////////////////////////////

    typedef struct packed {
        addr_t addr;
        id_t   id;
        len_t  len;
    } ar_req_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_beat_t;

    // return mux grant state
    typedef enum logic [1:0] {
        IDLE,
        SLV_BURST,
        ERR_BURST
    } rr_state_t;

endpackage

`default_nettype wire

// ==== src/ar_decoder.sv ====
`default_nettype none

module ar_decoder (
    input  wire                       aclk,
    input  wire                       aresetn,
    // master AR
    input  wire                       i_ar_valid,
    input  wire  xbar_pkg::ar_req_t   i_ar,
    output logic                      o_ar_ready,
    // toward the slave read ports
    output xbar_pkg::slv_sel_t        o_target,
    input  wire  xbar_pkg::slv_sel_t  i_port_ready,
    // toward the error FIFO
    input  wire                       i_err_full,
    output logic                      o_err_push,
    output xbar_pkg::ar_req_t         o_err_req
);

    xbar_pkg::addr_t    offset [xbar_pkg::SLV_NB];
    xbar_pkg::slv_sel_t hit;
    logic               unmapped;
    logic               misroute_seen;

    //////////////////////////////
    // window match
    //////////////////////////////

    // an address below the window start wraps to a large offset and misses
    always_comb begin
        for (int i = 0; i < xbar_pkg::SLV_NB; i++) begin
            offset[i] = i_ar.addr - xbar_pkg::SLV_START[i];
            hit[i]    = offset[i] <= (xbar_pkg::SLV_END[i] - xbar_pkg::SLV_START[i]);
        end
    end

    assign unmapped = ~|hit;
    assign o_target = hit;

    //////////////////////////////
    // ready and error push
    //////////////////////////////

    // mapped requests take ready from their own port only
    always_comb begin
        if (unmapped) begin
            o_ar_ready = ~i_err_full;
        end else begin
            o_ar_ready = |(hit & i_port_ready);
        end
    end

    // misroute is accepted here and answered later by the return mux
    assign o_err_push = i_ar_valid & unmapped & ~i_err_full;
    assign o_err_req  = i_ar;

    // set once the first misroute has been taken
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            misroute_seen <= 1'b0;
        end else if (o_err_push) begin
            misroute_seen <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/slv_read_port.sv ====
`default_nettype none

module slv_read_port #(
    parameter int SLV_IDX = 0
) (
    input  wire                      aclk,
    input  wire                      aresetn,
    // from the decoder
    input  wire                      i_sel,
    input  wire                      i_ar_valid,
    input  wire  xbar_pkg::ar_req_t  i_ar,
    output logic                     o_ar_ready,
    // slave AR
    output logic                     o_s_ar_valid,
    output xbar_pkg::ar_req_t        o_s_ar,
    input  wire                      i_s_ar_ready,
    // slave R
    input  wire                      i_s_r_valid,
    input  wire  xbar_pkg::r_beat_t  i_s_r,
    output logic                     o_s_r_ready,
    // toward the return mux
    output logic                     o_r_valid,
    output xbar_pkg::r_beat_t        o_r,
    input  wire                      i_r_ready
);

    xbar_pkg::ost_cnt_t ost_cnt;
    xbar_pkg::addr_t    win_offset;
    logic               in_window;
    logic               has_room;
    logic               ar_ok;
    logic               ar_xfer;
    logic               r_done;

    // this port never issues outside its own window
    assign win_offset = i_ar.addr - xbar_pkg::SLV_START[SLV_IDX];
    assign in_window  = win_offset <=
                        (xbar_pkg::SLV_END[SLV_IDX] - xbar_pkg::SLV_START[SLV_IDX]);

    assign has_room = ost_cnt < xbar_pkg::OSTD_MAX;
    assign ar_ok    = i_sel & in_window & has_room;

    assign o_s_ar_valid = i_ar_valid & ar_ok;
    assign o_s_ar       = i_ar;
    assign o_ar_ready   = i_s_ar_ready & ar_ok;

    // R beats flow straight through, the mux decides who drains
    assign o_r_valid   = i_s_r_valid;
    assign o_r         = i_s_r;
    assign o_s_r_ready = i_r_ready;

    assign ar_xfer = o_s_ar_valid & i_s_ar_ready;
    assign r_done  = i_s_r_valid & i_r_ready & i_s_r.last;

    //////////////////////////////
    // outstanding reads
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ost_cnt <= '0;
        end else if (ar_xfer && !r_done) begin
            ost_cnt <= ost_cnt + 1'b1;
        end else if (r_done && !ar_xfer) begin
            ost_cnt <= ost_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/r_return_mux.sv ====
`default_nettype none

module r_return_mux (
    input  wire                                             aclk,
    input  wire                                             aresetn,
    // misrouted requests from the decoder
    input  wire                                             i_err_push,
    input  wire  xbar_pkg::ar_req_t                         i_err_req,
    output logic                                            o_err_full,
    // slave R streams from the ports
    input  wire  xbar_pkg::slv_sel_t                        i_port_valid,
    input  wire  xbar_pkg::r_beat_t [xbar_pkg::SLV_NB-1:0]  i_port_r,
    output xbar_pkg::slv_sel_t                              o_port_ready,
    // master R
    output logic                                            o_r_valid,
    output xbar_pkg::r_beat_t                               o_r,
    input  wire                                             i_r_ready
);

    xbar_pkg::id_t                         err_id_mem  [xbar_pkg::ERR_DEPTH];
    xbar_pkg::len_t                        err_len_mem [xbar_pkg::ERR_DEPTH];
    logic [$clog2(xbar_pkg::ERR_DEPTH)-1:0] wr_addr;
    logic [$clog2(xbar_pkg::ERR_DEPTH)-1:0] rd_addr;
    logic                                  wr_wrap;
    logic                                  rd_wrap;
    logic                                  err_empty;
    logic                                  err_pop;
    logic                                  err_last;
    xbar_pkg::len_t                        beat_cnt;

    xbar_pkg::rr_state_t                   state;
    xbar_pkg::slv_sel_t                    grant_q;
    xbar_pkg::slv_sel_t                    rr_last;
    xbar_pkg::slv_sel_t                    pick;
    xbar_pkg::slv_sel_t                    slv_grant;
    logic                                  err_active;
    logic                                  r_xfer;
    logic                                  r_done;

    //////////////////////////////
    // error FIFO
    //////////////////////////////

    assign err_empty  = (wr_addr == rd_addr) && (wr_wrap == rd_wrap);
    assign o_err_full = (wr_addr == rd_addr) && (wr_wrap != rd_wrap);

    always_ff @(posedge aclk) begin
        if (i_err_push) begin
            err_id_mem[wr_addr]  <= i_err_req.id;
            err_len_mem[wr_addr] <= i_err_req.len;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            {wr_wrap, wr_addr} <= '0;
            {rd_wrap, rd_addr} <= '0;
        end else begin
            if (i_err_push) begin
                {wr_wrap, wr_addr} <= {wr_wrap, wr_addr} + 1'b1;
            end
            if (err_pop) begin
                {rd_wrap, rd_addr} <= {rd_wrap, rd_addr} + 1'b1;
            end
        end
    end

    // DECERR beat position within the head burst
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            beat_cnt <= '0;
        end else if (err_pop) begin
            beat_cnt <= '0;
        end else if (r_xfer && err_active) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign err_last = beat_cnt == err_len_mem[rd_addr];

    //////////////////////////////
    // grant selection
    //////////////////////////////

    // first requester after the last served slave
    always_comb begin
        int base;
        int cand;
        base = 0;
        pick = '0;
        for (int i = 0; i < xbar_pkg::SLV_NB; i++) begin
            if (rr_last[i]) begin
                base = i;
            end
        end
        // walk backwards so the nearest requester wins
        for (int k = xbar_pkg::SLV_NB; k >= 1; k--) begin
            cand = (base + k) % xbar_pkg::SLV_NB;
            if (i_port_valid[cand]) begin
                pick       = '0;
                pick[cand] = 1'b1;
            end
        end
    end

    // error path wins whenever no burst holds the grant
    assign err_active = (state == xbar_pkg::ERR_BURST) ||
                        (state == xbar_pkg::IDLE && !err_empty);

    always_comb begin
        if (state == xbar_pkg::SLV_BURST) begin
            slv_grant = grant_q;
        end else if (state == xbar_pkg::IDLE && err_empty) begin
            slv_grant = pick;
        end else begin
            slv_grant = '0;
        end
    end

    //////////////////////////////
    // R output
    //////////////////////////////

    always_comb begin
        o_r       = '0;
        o_r.resp  = xbar_pkg::RESP_OKAY;
        o_r_valid = 1'b0;
        if (err_active) begin
            o_r_valid = 1'b1;
            o_r.id    = err_id_mem[rd_addr];
            o_r.resp  = xbar_pkg::RESP_DECERR;
            o_r.last  = err_last;
        end else begin
            for (int i = 0; i < xbar_pkg::SLV_NB; i++) begin
                if (slv_grant[i]) begin
                    o_r_valid = i_port_valid[i];
                    o_r       = i_port_r[i];
                end
            end
        end
    end

    assign o_port_ready = slv_grant & {xbar_pkg::SLV_NB{i_r_ready}};

    assign r_xfer  = o_r_valid & i_r_ready;
    assign r_done  = r_xfer & o_r.last;
    assign err_pop = r_done & err_active;

    // any beat shown but not finished locks the grant
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= xbar_pkg::IDLE;
            grant_q <= '0;
            rr_last <= xbar_pkg::slv_sel_t'(1) << (xbar_pkg::SLV_NB - 1);
        end else begin
            case (state)
                xbar_pkg::IDLE: begin
                    if (err_active) begin
                        if (!r_done) begin
                            state <= xbar_pkg::ERR_BURST;
                        end
                    end else if (|pick) begin
                        grant_q <= pick;
                        if (r_done) begin
                            rr_last <= pick;
                        end else begin
                            state <= xbar_pkg::SLV_BURST;
                        end
                    end
                end
                xbar_pkg::SLV_BURST: begin
                    if (r_done) begin
                        state   <= xbar_pkg::IDLE;
                        rr_last <= grant_q;
                    end
                end
                xbar_pkg::ERR_BURST: begin
                    if (r_done) begin
                        state <= xbar_pkg::IDLE;
                    end
                end
                default: begin
                    state <= xbar_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/mst_read_switch.sv ====
`default_nettype none

module mst_read_switch (
    input  wire                                              aclk,
    input  wire                                              aresetn,
    // master AR
    input  wire                                              i_ar_valid,
    input  wire  xbar_pkg::ar_req_t                          i_ar,
    output logic                                             o_ar_ready,
    // master R
    output logic                                             o_r_valid,
    output xbar_pkg::r_beat_t                                o_r,
    input  wire                                              i_r_ready,
    // slave AR
    output xbar_pkg::slv_sel_t                               o_s_ar_valid,
    output xbar_pkg::ar_req_t [xbar_pkg::SLV_NB-1:0]         o_s_ar,
    input  wire  xbar_pkg::slv_sel_t                         i_s_ar_ready,
    // slave R
    input  wire  xbar_pkg::slv_sel_t                         i_s_r_valid,
    input  wire  xbar_pkg::r_beat_t [xbar_pkg::SLV_NB-1:0]   i_s_r,
    output xbar_pkg::slv_sel_t                               o_s_r_ready
);

    xbar_pkg::slv_sel_t                        dec_target;
    xbar_pkg::slv_sel_t                        port_ready;
    logic                                      err_push;
    xbar_pkg::ar_req_t                         err_req;
    logic                                      err_full;
    xbar_pkg::slv_sel_t                        port_r_valid;
    xbar_pkg::r_beat_t [xbar_pkg::SLV_NB-1:0]  port_r;
    xbar_pkg::slv_sel_t                        port_r_ready;

    ar_decoder u_dec (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_ar_valid   (i_ar_valid),
        .i_ar         (i_ar),
        .o_ar_ready   (o_ar_ready),
        .o_target     (dec_target),
        .i_port_ready (port_ready),
        .i_err_full   (err_full),
        .o_err_push   (err_push),
        .o_err_req    (err_req)
    );

    // one read port per slave
    for (genvar g = 0; g < xbar_pkg::SLV_NB; g++) begin : gen_port
        slv_read_port #(
            .SLV_IDX (g)
        ) u_port (
            .aclk         (aclk),
            .aresetn      (aresetn),
            .i_sel        (dec_target[g]),
            .i_ar_valid   (i_ar_valid),
            .i_ar         (i_ar),
            .o_ar_ready   (port_ready[g]),
            .o_s_ar_valid (o_s_ar_valid[g]),
            .o_s_ar       (o_s_ar[g]),
            .i_s_ar_ready (i_s_ar_ready[g]),
            .i_s_r_valid  (i_s_r_valid[g]),
            .i_s_r        (i_s_r[g]),
            .o_s_r_ready  (o_s_r_ready[g]),
            .o_r_valid    (port_r_valid[g]),
            .o_r          (port_r[g]),
            .i_r_ready    (port_r_ready[g])
        );
    end

    r_return_mux u_rmux (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_err_push   (err_push),
        .i_err_req    (err_req),
        .o_err_full   (err_full),
        .i_port_valid (port_r_valid),
        .i_port_r     (port_r),
        .o_port_ready (port_r_ready),
        .o_r_valid    (o_r_valid),
        .o_r          (o_r),
        .i_r_ready    (i_r_ready)
    );

endmodule

`default_nettype wire

// ==== verif/mst_read_switch_props.sv ====
`default_nettype none

module mst_read_switch_props (
    input wire                                             aclk,
    input wire                                             aresetn,
    input wire                                             i_ar_valid,
    input wire xbar_pkg::ar_req_t                          i_ar,
    input wire                                             o_ar_ready,
    input wire                                             o_r_valid,
    input wire xbar_pkg::r_beat_t                          o_r,
    input wire                                             i_r_ready,
    input wire xbar_pkg::slv_sel_t                         o_s_ar_valid,
    input wire xbar_pkg::ar_req_t [xbar_pkg::SLV_NB-1:0]   o_s_ar,
    input wire xbar_pkg::slv_sel_t                         i_s_ar_ready,
    input wire xbar_pkg::ost_cnt_t [xbar_pkg::SLV_NB-1:0]  i_ost_cnt,
    input wire                                             i_misroute_seen
);

    a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        i_ar_valid && !o_ar_ready |=> i_ar_valid && $stable(i_ar))
        else $error("master AR dropped or changed before ready");

    a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        o_r_valid && !i_r_ready |=> o_r_valid && $stable(o_r))
        else $error("R beat dropped or changed before ready");

    // a DECERR beat needs an earlier misroute
    a_decerr_src: assert property (@(posedge aclk) disable iff (!aresetn)
        o_r_valid && o_r.resp == xbar_pkg::RESP_DECERR |-> i_misroute_seen)
        else $error("DECERR beat without any misrouted request");

    for (genvar g = 0; g < xbar_pkg::SLV_NB; g++) begin : gen_slv_chk
        a_s_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
            o_s_ar_valid[g] && !i_s_ar_ready[g] |=> o_s_ar_valid[g] && $stable(o_s_ar[g]))
            else $error("slave %0d AR dropped or changed before ready", g);

        a_ost_max: assert property (@(posedge aclk) disable iff (!aresetn)
            i_ost_cnt[g] <= xbar_pkg::OSTD_MAX)
            else $error("slave %0d outstanding counter above limit", g);
    end

endmodule

bind mst_read_switch mst_read_switch_props u_props (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .i_ar_valid      (i_ar_valid),
    .i_ar            (i_ar),
    .o_ar_ready      (o_ar_ready),
    .o_r_valid       (o_r_valid),
    .o_r             (o_r),
    .i_r_ready       (i_r_ready),
    .o_s_ar_valid    (o_s_ar_valid),
    .o_s_ar          (o_s_ar),
    .i_s_ar_ready    (i_s_ar_ready),
    .i_ost_cnt       ({gen_port[2].u_port.ost_cnt,
                       gen_port[1].u_port.ost_cnt,
                       gen_port[0].u_port.ost_cnt}),
    .i_misroute_seen (u_dec.misroute_seen)
);

`default_nettype wire

// ==== verif/tb_mst_read_switch.sv ====
`default_nettype none

module tb_mst_read_switch;

    localparam int PERIOD      = 40;
    localparam int RST_CYC     = 10;
    localparam int N_REQ       = 200;
    localparam int CYC_PER_REQ = 40;
    // slaves stay silent this long so the ports fill up
    localparam int HOLD_CYC    = 300;

    logic                                      aclk;
    logic                                      aresetn;
    logic                                      i_ar_valid;
    xbar_pkg::ar_req_t                         i_ar;
    logic                                      o_ar_ready;
    logic                                      o_r_valid;
    xbar_pkg::r_beat_t                         o_r;
    logic                                      i_r_ready;
    xbar_pkg::slv_sel_t                        o_s_ar_valid;
    xbar_pkg::ar_req_t [xbar_pkg::SLV_NB-1:0]  o_s_ar;
    xbar_pkg::slv_sel_t                        i_s_ar_ready;
    xbar_pkg::slv_sel_t                        i_s_r_valid;
    xbar_pkg::r_beat_t [xbar_pkg::SLV_NB-1:0]  i_s_r;
    xbar_pkg::slv_sel_t                        o_s_r_ready;

    integer             seed = 50852;
    int                 mismatch_cnt;
    int                 fail_cnt;
    int                 issued;
    int                 open_cnt;
    int                 next_id;
    int                 cycle;
    int                 misroute_cnt;
    int                 ost_peak;
    logic               ar_fire;
    logic               r_fire;
    xbar_pkg::slv_sel_t s_ar_fire;
    xbar_pkg::slv_sel_t s_r_fire;
    logic               in_burst;
    xbar_pkg::id_t      cur_id;

    // reference record per ID
    // slave index 3 stands for DECERR
    bit                 rec_pend [16];
    int                 rec_slv  [16];
    int                 rec_len  [16];
    xbar_pkg::addr_t    rec_addr [16];
    int                 rec_beat [16];

    // slave models
    xbar_pkg::ar_req_t  slv_q [xbar_pkg::SLV_NB][$];
    int                 s_beat [xbar_pkg::SLV_NB];
    int                 s_wait [xbar_pkg::SLV_NB];
    int                 ost    [xbar_pkg::SLV_NB];

    mst_read_switch u_dut (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_ar_valid   (i_ar_valid),
        .i_ar         (i_ar),
        .o_ar_ready   (o_ar_ready),
        .o_r_valid    (o_r_valid),
        .o_r          (o_r),
        .i_r_ready    (i_r_ready),
        .o_s_ar_valid (o_s_ar_valid),
        .o_s_ar       (o_s_ar),
        .i_s_ar_ready (i_s_ar_ready),
        .i_s_r_valid  (i_s_r_valid),
        .i_s_r        (i_s_r),
        .o_s_r_ready  (o_s_r_ready)
    );

    always #(PERIOD / 2) aclk = ~aclk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic int pick_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // three 4 KiB windows from zero and nothing mapped above them
    function automatic int window_of(input xbar_pkg::addr_t addr);
        if (addr < 32'd4096) begin
            return 0;
        end
        if (addr < 32'd8192) begin
            return 1;
        end
        if (addr < 32'd12288) begin
            return 2;
        end
        return 3;
    endfunction

    // slave index, low address bits and beat number side by side
    function automatic xbar_pkg::data_t beat_data(input int slv, input xbar_pkg::addr_t addr,
                                                  input int beat);
        return {8'(slv), 4'h0, addr[11:0], 4'h0, 4'(beat)};
    endfunction

    task automatic flag_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
        mismatch_cnt++;
        $display("Mismatch %s: expected %h, actual %h at cycle %0d", test, exp, act, cycle);
    endtask

    task automatic flag_failure(input string msg);
        fail_cnt++;
        $display("Error: %s at cycle %0d", msg, cycle);
    endtask

    //////////////////////////////
    // reference model and checks
    //////////////////////////////

    task automatic accept_request(input xbar_pkg::ar_req_t req);
        int                 exp;
        xbar_pkg::slv_sel_t exp_mask;
        exp      = window_of(req.addr);
        exp_mask = '0;
        if (exp < 3) begin
            exp_mask[exp] = 1'b1;
        end else begin
            misroute_cnt++;
        end
        if (s_ar_fire != exp_mask) begin
            flag_mismatch("ar routing", 32'(exp_mask), 32'(s_ar_fire));
        end
        rec_pend[req.id] = 1'b1;
        rec_slv[req.id]  = exp;
        rec_len[req.id]  = int'(req.len);
        rec_addr[req.id] = req.addr;
        rec_beat[req.id] = 0;
        open_cnt++;
    endtask

    task automatic check_beat(input xbar_pkg::r_beat_t beat);
        int              id;
        int              n;
        logic            exp_last;
        xbar_pkg::data_t exp_data;
        xbar_pkg::resp_t exp_resp;
        id = int'(beat.id);
        if (!rec_pend[id]) begin
            flag_failure($sformatf("R beat with ID %0d that has no open request", id));
            return;
        end
        if (in_burst && beat.id != cur_id) begin
            flag_mismatch("burst lock id", 32'(cur_id), 32'(beat.id));
        end
        n        = rec_beat[id];
        exp_last = (n == rec_len[id]);
        if (rec_slv[id] == 3) begin
            exp_data = '0;
            exp_resp = xbar_pkg::RESP_DECERR;
            if (beat.data != exp_data) begin
                flag_mismatch("misroute data", exp_data, beat.data);
            end
        end else begin
            exp_data = beat_data(rec_slv[id], rec_addr[id], n);
            exp_resp = xbar_pkg::RESP_OKAY;
            if (beat.data != exp_data) begin
                flag_mismatch("routing data", exp_data, beat.data);
            end
        end
        if (beat.resp != exp_resp) begin
            flag_mismatch("response", 32'(exp_resp), 32'(beat.resp));
        end
        if (beat.last != exp_last) begin
            flag_mismatch("last flag", 32'(exp_last), 32'(beat.last));
        end
        rec_beat[id] = n + 1;
        if (beat.last || exp_last) begin
            rec_pend[id] = 1'b0;
            open_cnt--;
            in_burst = 1'b0;
        end else begin
            in_burst = 1'b1;
            cur_id   = beat.id;
        end
    endtask

    // sampled mid-cycle where every input and output has settled
    task automatic observe_cycle();
        ar_fire   = i_ar_valid && o_ar_ready;
        r_fire    = o_r_valid && i_r_ready;
        s_ar_fire = o_s_ar_valid & i_s_ar_ready;
        s_r_fire  = i_s_r_valid & o_s_r_ready;
        if (ar_fire) begin
            accept_request(i_ar);
        end else if (|s_ar_fire) begin
            flag_failure("slave AR transfer without a master AR transfer");
        end
        for (int s = 0; s < xbar_pkg::SLV_NB; s++) begin
            if (s_ar_fire[s]) begin
                slv_q[s].push_back(o_s_ar[s]);
                ost[s]++;
            end
            if (s_r_fire[s] && i_s_r[s].last) begin
                slv_q[s].delete(0);
                s_beat[s] = 0;
                ost[s]--;
                s_wait[s] = pick_below(8);
            end else if (s_r_fire[s]) begin
                s_beat[s]++;
                s_wait[s] = pick_below(3);
            end
            if (ost[s] > xbar_pkg::OSTD_MAX) begin
                flag_failure($sformatf("slave %0d has more than OSTD_MAX open reads", s));
            end
            if (ost[s] > ost_peak) begin
                ost_peak = ost[s];
            end
        end
        if (r_fire) begin
            check_beat(o_r);
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic drive_inputs();
        xbar_pkg::r_beat_t nb;
        xbar_pkg::ar_req_t head;
        if (!(i_ar_valid && !ar_fire)) begin
            i_ar_valid = 1'b0;
            if (issued < N_REQ && !rec_pend[next_id] && pick_below(4) != 0) begin
                i_ar.addr  = xbar_pkg::addr_t'(pick_below(16384));
                i_ar.id    = xbar_pkg::id_t'(next_id);
                i_ar.len   = xbar_pkg::len_t'(pick_below(16));
                i_ar_valid = 1'b1;
                next_id    = (next_id + 1) % 16;
                issued++;
            end
        end
        i_r_ready = (pick_below(10) < 7);
        for (int s = 0; s < xbar_pkg::SLV_NB; s++) begin
            i_s_ar_ready[s] = (pick_below(4) != 0);
            if (!(i_s_r_valid[s] && !s_r_fire[s])) begin
                i_s_r_valid[s] = 1'b0;
                if (slv_q[s].size() != 0 && cycle >= HOLD_CYC) begin
                    if (s_wait[s] > 0) begin
                        s_wait[s]--;
                    end else begin
                        head           = slv_q[s][0];
                        nb.id          = head.id;
                        nb.data        = beat_data(s, head.addr, s_beat[s]);
                        nb.resp        = xbar_pkg::RESP_OKAY;
                        nb.last        = (s_beat[s] == int'(head.len));
                        i_s_r[s]       = nb;
                        i_s_r_valid[s] = 1'b1;
                    end
                end
            end
        end
    endtask

    initial begin
        aclk         = 1'b0;
        aresetn      = 1'b0;
        i_ar_valid   = 1'b0;
        i_ar         = '0;
        i_r_ready    = 1'b0;
        i_s_ar_ready = '0;
        i_s_r_valid  = '0;
        i_s_r        = '0;
        for (int s = 0; s < xbar_pkg::SLV_NB; s++) begin
            s_beat[s] = 0;
            s_wait[s] = 0;
            ost[s]    = 0;
        end
        repeat (RST_CYC) @(posedge aclk);
        #1;
        if (o_r_valid || |o_s_ar_valid || |o_s_r_ready) begin
            flag_failure("outputs not idle during reset");
        end
        aresetn = 1'b1;
        while (!(issued == N_REQ && open_cnt == 0 && !i_ar_valid)) begin
            @(negedge aclk);
            observe_cycle();
            @(posedge aclk);
            #1;
            drive_inputs();
            cycle++;
        end
        for (int s = 0; s < xbar_pkg::SLV_NB; s++) begin
            if (slv_q[s].size() != 0 || ost[s] != 0) begin
                flag_failure($sformatf("slave %0d still holds requests at the end", s));
            end
        end
        if (ost_peak != xbar_pkg::OSTD_MAX) begin
            flag_mismatch("outstanding peak", 32'(xbar_pkg::OSTD_MAX), 32'(ost_peak));
        end
        if (misroute_cnt == 0) begin
            flag_failure("no misrouted request was sent");
        end
        $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // budget of cycles per request covers the slowest random case
    initial begin
        #(N_REQ * CYC_PER_REQ * PERIOD);
        $display("watchdog expired with %0d requests still open", open_cnt);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
src/xbar_pkg.sv
src/ar_decoder.sv
src/slv_read_port.sv
src/r_return_mux.sv
src/mst_read_switch.sv
verif/mst_read_switch_props.sv
verif/tb_mst_read_switch.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the read switch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mst_read_switch \
    -f flist.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
